// ==== source/zx_mem_pkg.sv ====
package zx_mem_pkg;

	// four 16k windows cover the whole z80 address space
	localparam int window_count = 4;

	// ram page number as seen by the dram side
	typedef logic [7:0] page_t;

	// rom chip page
	typedef logic [4:0] rom_page_t;

	// xxF7 byte when the window maps ram
	typedef struct packed
	{
		logic       ram_sel;
		logic       follow_7ffd;
		logic [5:0] page;
	} ram_view_t;

	// xxF7 byte when the window maps rom
	typedef struct packed
	{
		logic       ram_sel;
		logic       follow_dos;
		logic       spare;
		logic [4:0] rom_page;
	} rom_view_t;

	// one pager byte, two readings selected by ram_sel
	typedef union packed
	{
		ram_view_t ram;
		rom_view_t rom;
	} page_word_t;

	// pentagon layout, fixed pages of windows 1 and 2
	localparam page_t pent_ram_w1 = 8'd5;
	localparam page_t pent_ram_w2 = 8'd2;

endpackage

// ==== source/zx_port_pkg.sv ====
package zx_port_pkg;

	// FE, only A0 is decoded
	localparam logic [15:0] port_fe_mask  = 16'h0001;
	localparam logic [15:0] port_fe_match = 16'h0000;
	localparam int port_fe_border_msb = 2;
	localparam int port_fe_border_lsb = 0;
	localparam int port_fe_beeper_bit = 4;

	// 7FFD, A15 A1 A0 decoded
	localparam logic [15:0] port_7ffd_mask  = 16'h8003;
	localparam logic [15:0] port_7ffd_match = 16'h0001;
	localparam int port_7ffd_ram_msb  = 2;
	localparam int port_7ffd_ram_lsb  = 0;
	localparam int port_7ffd_scr_bit  = 3;
	localparam int port_7ffd_rom_bit  = 4;
	localparam int port_7ffd_lock_bit = 5;

	// full low byte ports, window index on A15..A14
	localparam logic [7:0] port_f7_lo = 8'hF7;
	localparam logic [7:0] port_be_lo = 8'hBE;
	localparam logic [7:0] port_fb_lo = 8'hFB;

	// configuration port
	localparam logic [7:0] port_77_lo = 8'h77;
	localparam int port_77_pager_en_bit  = 0;
	localparam int port_77_cpm_n_bit     = 1;
	localparam int port_77_sound_mux_bit = 2;

endpackage

// ==== source/port_decoder.sv ====
`timescale 1ns/1ps

module port_decoder
(
	input  logic                                          fclk,
	input  logic                                          arst_n,
	input  logic [15:0]                                   a,
	input  logic [7:0]                                    d_in,
	input  logic                                          iorq_n,
	input  logic                                          wr_n,
	input  logic                                          rd_n,
	input  logic                                          m1_n,
	input  zx_mem_pkg::page_word_t                        win_word0,
	input  zx_mem_pkg::page_word_t                        win_word1,
	input  zx_mem_pkg::page_word_t                        win_word2,
	input  zx_mem_pkg::page_word_t                        win_word3,
	output logic [7:0]                                    d_out,
	output logic                                          d_oe,
	output logic                                          f7_wr,
	output logic [$clog2(zx_mem_pkg::window_count)-1:0]   f7_window,
	output zx_mem_pkg::page_word_t                        f7_data,
	output logic [7:0]                                    p7ffd,
	output logic [2:0]                                    border,
	output logic                                          beeper,
	output logic                                          pager_en,
	output logic                                          cpm_n,
	output logic                                          sound_mux,
	output logic                                          covox_wr,
	output logic [7:0]                                    covox_data
);

	logic [15:0] a_q;
	logic [7:0]  d_q;
	logic        iorq_q;
	logic        wr_q;
	logic        rd_q;
	logic        m1_q;
	logic        io_wr;
	logic        io_rd;
	logic        io_wr_prev;
	logic        wr_pulse;
	logic        fe_hit;
	logic        p7ffd_hit;
	logic        byte_hit;
	logic        fe_wr_q;
	logic        p7ffd_wr_q;
	logic        p77_wr_q;
	logic [7:0]  wr_data_q;
	logic        rd_hit_q;
	logic [$clog2(zx_mem_pkg::window_count)-1:0] rd_win_q;
	zx_mem_pkg::page_word_t rd_word;

	////////////////////////////////////////////////////////////////////////////
	// bus sampling
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			iorq_q <= 1'b1;
			wr_q   <= 1'b1;
			rd_q   <= 1'b1;
			m1_q   <= 1'b1;
		end
		else
		begin
			iorq_q <= iorq_n;
			wr_q   <= wr_n;
			rd_q   <= rd_n;
			m1_q   <= m1_n;
		end
	end

	always_ff @(posedge fclk)
	begin
		a_q <= a;
		d_q <= d_in;
	end

	// m1 high keeps interrupt acknowledge out
	assign io_wr    = !iorq_q && !wr_q && m1_q;
	assign io_rd    = !iorq_q && !rd_q && m1_q;
	assign wr_pulse = io_wr && !io_wr_prev;

	// FE wins over 7FFD, both win over the full byte ports
	assign fe_hit    = (a_q & zx_port_pkg::port_fe_mask) == zx_port_pkg::port_fe_match;
	assign p7ffd_hit = !fe_hit
		&& ((a_q & zx_port_pkg::port_7ffd_mask) == zx_port_pkg::port_7ffd_match);
	assign byte_hit  = !fe_hit && !p7ffd_hit;

	////////////////////////////////////////////////////////////////////////////
	// stage one, write pulses and read hit
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			io_wr_prev <= 1'b0;
			fe_wr_q    <= 1'b0;
			p7ffd_wr_q <= 1'b0;
			p77_wr_q   <= 1'b0;
			f7_wr      <= 1'b0;
			covox_wr   <= 1'b0;
			rd_hit_q   <= 1'b0;
		end
		else
		begin
			io_wr_prev <= io_wr;
			fe_wr_q    <= wr_pulse && fe_hit;
			p7ffd_wr_q <= wr_pulse && p7ffd_hit;
			p77_wr_q   <= wr_pulse && byte_hit && a_q[7:0] == zx_port_pkg::port_77_lo;
			f7_wr      <= wr_pulse && byte_hit && a_q[7:0] == zx_port_pkg::port_f7_lo;
			covox_wr   <= wr_pulse && byte_hit && a_q[7:0] == zx_port_pkg::port_fb_lo;
			rd_hit_q   <= io_rd && a_q[7:0] == zx_port_pkg::port_be_lo;
		end
	end

	always_ff @(posedge fclk)
	begin
		wr_data_q <= d_q;
		f7_window <= a_q[15:14];
		rd_win_q  <= a_q[15:14];
	end

	assign f7_data    = zx_mem_pkg::page_word_t'(wr_data_q);
	assign covox_data = wr_data_q;

	////////////////////////////////////////////////////////////////////////////
	// stage two, port registers and readback
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			border    <= 3'd0;
			beeper    <= 1'b0;
			p7ffd     <= 8'd0;
			pager_en  <= 1'b0;
			cpm_n     <= 1'b1;
			sound_mux <= 1'b0;
			d_oe      <= 1'b0;
		end
		else
		begin
			if (fe_wr_q)
			begin
				border <= wr_data_q[zx_port_pkg::port_fe_border_msb:zx_port_pkg::port_fe_border_lsb];
				beeper <= wr_data_q[zx_port_pkg::port_fe_beeper_bit];
			end
			// lock bit sticks until reset
			if (p7ffd_wr_q && !p7ffd[zx_port_pkg::port_7ffd_lock_bit])
				p7ffd <= wr_data_q;
			if (p77_wr_q)
			begin
				pager_en  <= wr_data_q[zx_port_pkg::port_77_pager_en_bit];
				cpm_n     <= wr_data_q[zx_port_pkg::port_77_cpm_n_bit];
				sound_mux <= wr_data_q[zx_port_pkg::port_77_sound_mux_bit];
			end
			d_oe <= rd_hit_q;
		end
	end

	always_comb
	begin
		case (rd_win_q)
			2'd0:    rd_word = win_word0;
			2'd1:    rd_word = win_word1;
			2'd2:    rd_word = win_word2;
			default: rd_word = win_word3;
		endcase
	end

	// readback is inverted, as on the ATM
	always_ff @(posedge fclk)
		d_out <= ~rd_word;

	a_one_write: assert property (@(posedge fclk) disable iff (!arst_n)
		$onehot0({fe_wr_q, p7ffd_wr_q, p77_wr_q, f7_wr, covox_wr}));

endmodule

// ==== source/window_pager.sv ====
`timescale 1ns/1ps

module window_pager
#(
	parameter int WINDOW = 0
)
(
	input  logic                                          fclk,
	input  logic                                          arst_n,
	input  logic                                          f7_wr,
	input  logic [$clog2(zx_mem_pkg::window_count)-1:0]   f7_window,
	input  zx_mem_pkg::page_word_t                        f7_data,
	input  logic                                          pager_en,
	input  logic [7:0]                                    p7ffd,
	input  logic                                          dos,
	output zx_mem_pkg::page_word_t                        win_word,
	output zx_mem_pkg::page_t                             win_page,
	output logic                                          win_rom,
	output zx_mem_pkg::rom_page_t                         win_rom_page
);

	localparam int win_bits = $clog2(zx_mem_pkg::window_count);
	localparam logic [win_bits-1:0] win_idx = win_bits'(WINDOW);

	logic [5:0]            pg_ram;
	zx_mem_pkg::rom_page_t pg_rom;

	// pager word, written through xxF7 for this window only
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			win_word <= '0;
		else if (f7_wr && f7_window == win_idx)
			win_word <= f7_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// page decode
	always_comb
	begin
		pg_ram = win_word.ram.page;
		if (win_word.ram.follow_7ffd)
			pg_ram[2:0] = p7ffd[zx_port_pkg::port_7ffd_ram_msb:zx_port_pkg::port_7ffd_ram_lsb];

		// dos low selects the upper rom half
		pg_rom = win_word.rom.rom_page;
		if (win_word.rom.follow_dos)
			pg_rom[0] = ~dos;

		if (pager_en)
		begin
			win_rom      = !win_word.ram.ram_sel;
			win_page     = zx_mem_pkg::page_t'(pg_ram);
			win_rom_page = pg_rom;
		end
		else
		begin
			// plain pentagon 128 layout
			win_rom      = 1'b0;
			win_page     = 8'd0;
			win_rom_page = {3'b000, ~dos, p7ffd[zx_port_pkg::port_7ffd_rom_bit]};
			case (WINDOW)
				0:       win_rom  = 1'b1;
				1:       win_page = zx_mem_pkg::pent_ram_w1;
				2:       win_page = zx_mem_pkg::pent_ram_w2;
				default: win_page = {5'd0,
					p7ffd[zx_port_pkg::port_7ffd_ram_msb:zx_port_pkg::port_7ffd_ram_lsb]};
			endcase
		end
	end

	a_pent_rom_w0: assert property (@(posedge fclk) disable iff (!arst_n)
		(WINDOW != 0 && !pager_en) |-> !win_rom);

endmodule

// ==== source/dos_control.sv ====
`timescale 1ns/1ps

module dos_control
(
	input  logic        fclk,
	input  logic        arst_n,
	input  logic [15:0] a,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        cpm_n,
	input  logic        win0_rom,
	output logic        dos
);

	logic [15:0] a_q;
	logic        mreq_q;
	logic        m1_q;
	logic        fetch;
	logic        dos_on_q;
	logic        dos_off_q;

	always_ff @(posedge fclk)
		a_q <= a;

	assign fetch = !m1_q && !mreq_q;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mreq_q    <= 1'b1;
			m1_q      <= 1'b1;
			dos_on_q  <= 1'b0;
			dos_off_q <= 1'b0;
			dos       <= 1'b0;
		end
		else
		begin
			mreq_q    <= mreq_n;
			m1_q      <= m1_n;
			// trdos entry points live at 3Dxx of the rom
			dos_on_q  <= fetch && a_q[15:8] == 8'h3D && win0_rom;
			dos_off_q <= fetch && a_q[15:14] != 2'b00;
			if (!cpm_n || dos_on_q)
				dos <= 1'b1;
			else if (dos_off_q)
				dos <= 1'b0;
		end
	end

	a_cpm_dos: assert property (@(posedge fclk) disable iff (!arst_n) !cpm_n |=> dos);

endmodule

// ==== source/mem_mapper.sv ====
`timescale 1ns/1ps

module mem_mapper
(
	input  logic [15:0]           a,
	input  logic                  mreq_n,
	input  zx_mem_pkg::page_t     win_page0,
	input  zx_mem_pkg::page_t     win_page1,
	input  zx_mem_pkg::page_t     win_page2,
	input  zx_mem_pkg::page_t     win_page3,
	input  logic                  win_rom0,
	input  logic                  win_rom1,
	input  logic                  win_rom2,
	input  logic                  win_rom3,
	input  zx_mem_pkg::rom_page_t win_rom_page0,
	input  zx_mem_pkg::rom_page_t win_rom_page1,
	input  zx_mem_pkg::rom_page_t win_rom_page2,
	input  zx_mem_pkg::rom_page_t win_rom_page3,
	output zx_mem_pkg::page_t     mem_page,
	output logic                  mem_rom,
	output logic                  cs_rom,
	output zx_mem_pkg::rom_page_t rompg
);

	// window select by the top two address bits
	always_comb
	begin
		case (a[15:14])
			2'd0:
			begin
				mem_page = win_page0;
				mem_rom  = win_rom0;
				rompg    = win_rom_page0;
			end
			2'd1:
			begin
				mem_page = win_page1;
				mem_rom  = win_rom1;
				rompg    = win_rom_page1;
			end
			2'd2:
			begin
				mem_page = win_page2;
				mem_rom  = win_rom2;
				rompg    = win_rom_page2;
			end
			default:
			begin
				mem_page = win_page3;
				mem_rom  = win_rom3;
				rompg    = win_rom_page3;
			end
		endcase
	end

	assign cs_rom = !mreq_n && mem_rom;

endmodule

// ==== source/sound_out.sv ====
`timescale 1ns/1ps

module sound_out
(
	input  logic       fclk,
	input  logic       arst_n,
	input  logic       beeper,
	input  logic       sound_mux,
	input  logic       covox_wr,
	input  logic [7:0] covox_data,
	output logic       beep
);

	logic [7:0] sample;
	logic [7:0] acc;
	logic       carry;

	////////////////////////////////////////////////////////////////////////////
	// covox, first order sigma-delta
	//
	// carry density is sample/256, so any 256 cycles with a steady
	// sample give exactly sample carries
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sample <= 8'd0;
			acc    <= 8'd0;
			carry  <= 1'b0;
		end
		else if (covox_wr)
		begin
			// restart the phase with the new sample
			sample <= covox_data;
			acc    <= 8'd0;
			carry  <= 1'b0;
		end
		else
		begin
			{carry, acc} <= {1'b0, acc} + {1'b0, sample};
		end
	end

	// beeper or covox to the pin
	assign beep = sound_mux ? carry : beeper;

endmodule

// ==== source/zx_core_top.sv ====
`timescale 1ns/1ps

module zx_core_top
(
	input  logic                  fclk,
	input  logic                  arst_n,
	input  logic [15:0]           a,
	input  logic [7:0]            d_in,
	input  logic                  iorq_n,
	input  logic                  mreq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic                  m1_n,
	output logic [7:0]            d_out,
	output logic                  d_oe,
	output logic [2:0]            border,
	output zx_mem_pkg::page_t     mem_page,
	output logic                  mem_rom,
	output logic                  cs_rom,
	output zx_mem_pkg::rom_page_t rompg,
	output logic                  beep,
	output logic                  dos
);

	logic                                        f7_wr;
	logic [$clog2(zx_mem_pkg::window_count)-1:0] f7_window;
	zx_mem_pkg::page_word_t                      f7_data;
	logic [7:0]                                  p7ffd;
	logic                                        beeper;
	logic                                        pager_en;
	logic                                        cpm_n;
	logic                                        sound_mux;
	logic                                        covox_wr;
	logic [7:0]                                  covox_data;

	// per window pager state
	zx_mem_pkg::page_word_t win_word     [zx_mem_pkg::window_count];
	zx_mem_pkg::page_t      win_page     [zx_mem_pkg::window_count];
	logic                   win_rom      [zx_mem_pkg::window_count];
	zx_mem_pkg::rom_page_t  win_rom_page [zx_mem_pkg::window_count];

	port_decoder i_ports
	(
		.fclk(fclk), .arst_n(arst_n),
		.a(a), .d_in(d_in), .iorq_n(iorq_n), .wr_n(wr_n), .rd_n(rd_n), .m1_n(m1_n),
		.win_word0(win_word[0]), .win_word1(win_word[1]),
		.win_word2(win_word[2]), .win_word3(win_word[3]),
		.d_out(d_out), .d_oe(d_oe),
		.f7_wr(f7_wr), .f7_window(f7_window), .f7_data(f7_data),
		.p7ffd(p7ffd), .border(border), .beeper(beeper),
		.pager_en(pager_en), .cpm_n(cpm_n), .sound_mux(sound_mux),
		.covox_wr(covox_wr), .covox_data(covox_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// ATM pagers, one per 16k window
	genvar w;
	for (w = 0; w < zx_mem_pkg::window_count; w++)
	begin : g_pager
		window_pager #(.WINDOW(w)) i_pager
		(
			.fclk(fclk), .arst_n(arst_n),
			.f7_wr(f7_wr), .f7_window(f7_window), .f7_data(f7_data),
			.pager_en(pager_en), .p7ffd(p7ffd), .dos(dos),
			.win_word(win_word[w]), .win_page(win_page[w]),
			.win_rom(win_rom[w]), .win_rom_page(win_rom_page[w])
		);
	end

	dos_control i_dos
	(
		.fclk(fclk), .arst_n(arst_n), .a(a), .mreq_n(mreq_n), .m1_n(m1_n),
		.cpm_n(cpm_n), .win0_rom(win_rom[0]), .dos(dos)
	);

	mem_mapper i_mapper
	(
		.a(a), .mreq_n(mreq_n),
		.win_page0(win_page[0]), .win_page1(win_page[1]),
		.win_page2(win_page[2]), .win_page3(win_page[3]),
		.win_rom0(win_rom[0]), .win_rom1(win_rom[1]),
		.win_rom2(win_rom[2]), .win_rom3(win_rom[3]),
		.win_rom_page0(win_rom_page[0]), .win_rom_page1(win_rom_page[1]),
		.win_rom_page2(win_rom_page[2]), .win_rom_page3(win_rom_page[3]),
		.mem_page(mem_page), .mem_rom(mem_rom), .cs_rom(cs_rom), .rompg(rompg)
	);

	sound_out i_sound
	(
		.fclk(fclk), .arst_n(arst_n), .beeper(beeper), .sound_mux(sound_mux),
		.covox_wr(covox_wr), .covox_data(covox_data), .beep(beep)
	);

endmodule

// ==== bench/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// z80 bus cycles that start and end on a falling edge

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	a      = addr;
	d_in   = data;
	m1_n   = 1'b1;
	iorq_n = 1'b0;
	wr_n   = 1'b0;
	repeat (bus_hold) @(negedge fclk);
	iorq_n = 1'b1;
	wr_n   = 1'b1;
	repeat (2) @(negedge fclk);
endtask

// d_oe is the only sign that read data is there
task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
	int n;
	a      = addr;
	m1_n   = 1'b1;
	iorq_n = 1'b0;
	rd_n   = 1'b0;
	n      = 0;
	while (d_oe !== 1'b1 && n < wait_limit)
	begin
		@(negedge fclk);
		n++;
	end
	if (d_oe !== 1'b1)
		report_timeout("d_oe never rose during the I/O read");
	data = d_out;
	while (n < bus_hold)
	begin
		@(negedge fclk);
		n++;
	end
	iorq_n = 1'b1;
	rd_n   = 1'b1;
	n      = 0;
	while (d_oe !== 1'b0 && n < wait_limit)
	begin
		@(negedge fclk);
		n++;
	end
	if (d_oe !== 1'b0)
		report_timeout("d_oe stayed high after the I/O read ended");
endtask

// opcode fetch with m1 and mreq low together
task automatic m1_fetch(input logic [15:0] addr);
	a      = addr;
	m1_n   = 1'b0;
	mreq_n = 1'b0;
	rd_n   = 1'b0;
	repeat (bus_hold) @(negedge fclk);
	m1_n   = 1'b1;
	mreq_n = 1'b1;
	rd_n   = 1'b1;
	repeat (2) @(negedge fclk);
endtask

task automatic wait_dos(input logic val);
	int n;
	n = 0;
	while (dos !== val && n < wait_limit)
	begin
		@(negedge fclk);
		n++;
	end
	if (dos !== val)
		report_timeout($sformatf("dos did not reach %0b in time", val));
endtask

`endif

// ==== bench/tb_zx_core.sv ====
`timescale 1ns/1ps

module tb_zx_core;

	localparam int bus_hold   = 6;
	localparam int wait_limit = 20;

	localparam logic [15:0] addr_fe   = 16'h00FE;
	localparam logic [15:0] addr_7ffd = 16'h7FFD;
	localparam logic [15:0] addr_77   = 16'h3F77;
	localparam logic [15:0] addr_fb   = 16'h3FFB;

	logic        fclk;
	logic        arst_n;
	logic [15:0] a;
	logic [7:0]  d_in;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic [7:0]  d_out;
	logic        d_oe;
	logic [2:0]  border;
	logic [7:0]  mem_page;
	logic        mem_rom;
	logic        cs_rom;
	logic [4:0]  rompg;
	logic        beep;
	logic        dos;

	// reference state of the machine
	logic [7:0]  m_7ffd;
	logic        m_pager_en;
	logic        m_dos;
	logic [7:0]  m_word [4];

	int          seed = 32'h0117_ab55;
	int          errors;
	int          checks;
	int          tests;
	int          failed;
	int          test_err0;
	string       test_name;
	int          i;
	int          r;
	int          w;
	int          high;
	logic [1:0]  wb;
	logic [7:0]  val;
	logic [7:0]  word;
	logic [7:0]  rd;

	zx_core_top i_dut
	(
		.fclk(fclk), .arst_n(arst_n), .a(a), .d_in(d_in),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.d_out(d_out), .d_oe(d_oe), .border(border), .mem_page(mem_page),
		.mem_rom(mem_rom), .cs_rom(cs_rom), .rompg(rompg), .beep(beep), .dos(dos)
	);

	initial
		fclk = 1'b0;

	always #20 fclk = ~fclk;

	////////////////////////////////////////////////////////////////////////////
	// checks and report

	task automatic expect_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("mismatch at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
		end
	endtask

	// no rom select outside a memory cycle
	cs_rom_rule: assert property (@(posedge fclk) disable iff (!arst_n)
		mreq_n |-> !cs_rom)
	else
	begin
		errors++;
		$display("mismatch at %0t: cs_rom expected 0, actual %0b", $time, $sampled(cs_rom));
	end

	// readback only answers an I/O read seen two edges before
	d_oe_rule: assert property (@(posedge fclk) disable iff (!arst_n)
		$rose(d_oe) |-> $past(!iorq_n && !rd_n, 2))
	else
	begin
		errors++;
		$display("d_oe rose at %0t without an I/O read before it", $time);
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test;
		tests++;
		if (errors != test_err0)
			failed++;
		$display("test %s finished, %0d errors", test_name, errors - test_err0);
	endtask

	task automatic finish_run;
		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	task automatic report_timeout(input string reason);
		errors++;
		$display("timeout in test %s: %s", test_name, reason);
	endtask

	`include "tb_bus_tasks.svh"

	// expected mapping of one window from the reference state
	function automatic void expected_map(input logic [1:0] win, output logic rom,
		output logic [7:0] page, output logic [4:0] rp);
		logic [7:0] pw;
		pw = m_word[win];
		if (!m_pager_en)
		begin
			rom = (win == 2'd0);
			rp  = {3'b000, ~m_dos, m_7ffd[4]};
			case (win)
				2'd1:    page = 8'd5;
				2'd2:    page = 8'd2;
				default: page = {5'b00000, m_7ffd[2:0]};
			endcase
		end
		else
		begin
			// bit 6 is the follow flag of either view
			rom  = !pw[7];
			page = {2'b00, pw[5:0]};
			rp   = pw[4:0];
			if (pw[6])
			begin
				page[2:0] = m_7ffd[2:0];
				rp[0]     = ~m_dos;
			end
		end
	endfunction

	task automatic check_map(input logic [15:0] addr);
		logic       exp_rom;
		logic [7:0] exp_page;
		logic [4:0] exp_rp;
		expected_map(addr[15:14], exp_rom, exp_page, exp_rp);
		a      = addr;
		mreq_n = 1'b0;
		@(negedge fclk);
		expect_eq("mem_rom", exp_rom, mem_rom);
		expect_eq("cs_rom", exp_rom, cs_rom);
		if (exp_rom)
			expect_eq("rompg", exp_rp, rompg);
		else
			expect_eq("mem_page", exp_page, mem_page);
		mreq_n = 1'b1;
	endtask

	// a locked 7FFD ignores the write
	task automatic write_7ffd(input logic [7:0] data);
		io_write(addr_7ffd, data);
		if (!m_7ffd[5])
			m_7ffd = data;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests

	initial
	begin
		a          = 16'h0000;
		d_in       = 8'h00;
		iorq_n     = 1'b1;
		mreq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		arst_n     = 1'b0;
		m_7ffd     = 8'h00;
		m_pager_en = 1'b0;
		m_dos      = 1'b0;
		for (i = 0; i < 4; i++)
			m_word[i] = 8'h00;
		repeat (4) @(negedge fclk);
		arst_n = 1'b1;
		@(negedge fclk);

		begin_test("reset_layout");
		check_map(16'h0000);
		check_map(16'h4000);
		check_map(16'h8000);
		check_map(16'hC000);
		end_test();

		begin_test("port_7ffd");
		for (i = 0; i < 4; i++)
		begin
			val    = $random(seed);
			val[5] = 1'b0;
			write_7ffd(val);
			check_map(16'h0000);
			check_map(16'hC000);
		end
		val    = $random(seed);
		val[5] = 1'b1;
		write_7ffd(val);
		for (i = 0; i < 3; i++)
		begin
			write_7ffd($random(seed));
			check_map(16'h0000);
			check_map(16'hC000);
		end
		end_test();

		begin_test("atm_pager");
		io_write(addr_77, 8'h03);
		m_pager_en = 1'b1;
		// two rounds reach every ram/rom and follow combination
		for (r = 0; r < 2; r++)
		begin
			for (w = 0; w < 4; w++)
			begin
				wb      = w[1:0];
				word    = $random(seed);
				word[7] = wb[0] ^ r[0];
				word[6] = wb[1] ^ r[0];
				io_write({wb, 6'h3F, 8'hF7}, word);
				m_word[w] = word;
			end
			for (w = 0; w < 4; w++)
			begin
				wb = w[1:0];
				check_map({wb, 14'h0123});
				io_read({wb, 6'h15, 8'hBE}, rd);
				expect_eq("d_out", 8'(~m_word[w]), rd);
			end
		end
		io_write(addr_77, 8'h02);
		m_pager_en = 1'b0;
		check_map(16'h0000);
		end_test();

		begin_test("dos_rom");
		m1_fetch(16'h3D00);
		wait_dos(1'b1);
		m_dos = 1'b1;
		check_map(16'h0000);
		m1_fetch(16'h4000);
		wait_dos(1'b0);
		m_dos = 1'b0;
		check_map(16'h0000);
		io_write(addr_77, 8'h00);
		wait_dos(1'b1);
		m_dos = 1'b1;
		m1_fetch(16'h4000);
		expect_eq("dos", 1'b1, dos);
		io_write(addr_77, 8'h02);
		end_test();

		begin_test("border_sound");
		for (i = 0; i < 2; i++)
		begin
			val    = $random(seed);
			val[4] = i[0];
			io_write(addr_fe, val);
			expect_eq("border", val[2:0], border);
			expect_eq("beep", val[4], beep);
		end
		io_write(addr_77, 8'h06);
		val = $random(seed);
		io_write(addr_fb, val);
		high = 0;
		for (i = 0; i < 256; i++)
		begin
			if (beep)
				high++;
			@(negedge fclk);
		end
		expect_eq("beep high count", val, high[15:0]);
		end_test();

		finish_run();
	end

endmodule

// ==== all.f ====
source/zx_mem_pkg.sv
source/zx_port_pkg.sv
source/port_decoder.sv
source/window_pager.sv
source/dos_control.sv
source/mem_mapper.sv
source/sound_out.sv
source/zx_core_top.sv
+incdir+bench
bench/tb_zx_core.sv
